// ==== bench/cpuBench.sv ====
`timescale 1ns/100ps

module cpuBench;
	import cpuPkg::*;

	localparam int KINDALUR = 0;
	localparam int KINDIMM = 1;
	localparam int KINDBRANCH = 2;
	localparam int KINDLOADUSE = 3;
	localparam int KINDJAL = 4;
	localparam int TIMEOUTCYCLES = 200;
	// word slot of the JAL inside its program
	localparam int JALSLOT = 3;
	localparam logic [DBITS-1:0] TAKENVAL = 32'h155;
	localparam logic [DBITS-1:0] NOTTAKENVAL = 32'h2AA;
	localparam logic [DBITS-1:0] POISON = 32'h1BAD;

	logic clk;
	logic reset;
	logic imemWrite;
	logic [IMEMADDRBITS-WORDBITS-1:0] imemAddr;
	logic [DBITS-1:0] imemData;
	logic [HEXBITS-1:0] hexValue;
	logic [LEDRBITS-1:0] ledr;

	// test table, one entry per row
	string rowName[$];
	int rowKind[$];
	logic [5:0] rowOp[$];
	logic [DBITS-1:0] rowA[$];
	logic [DBITS-1:0] rowB[$];
	logic [HEXBITS-1:0] rowHex[$];
	logic [LEDRBITS-1:0] rowLedr[$];

	logic [DBITS-1:0] prog[$];
	logic [31:0] lcgState;
	int errors;
	int checks;

	pipelineCpu i_dut (
		.clk(clk), .reset(reset),
		.imemWrite(imemWrite), .imemAddr(imemAddr), .imemData(imemData),
		.hexValue(hexValue), .ledr(ledr)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// signed value small enough for an ADDI from r0
	function automatic logic [DBITS-1:0] randomOperand();
		lcgState = lcgNext(lcgState);
		return {{(DBITS-IMMBITS){lcgState[29]}}, lcgState[29:16]};
	endfunction

	function automatic logic [DBITS-1:0] encodeR(input logic [5:0] func, input logic [5:0] rd,
			input logic [5:0] rs, input logic [5:0] rt);
		logic [DBITS-1:0] inst;
		inst = '0;
		inst[OP1HI:OP1LO] = ALUR;
		inst[RSHI:RSLO] = rs;
		inst[RTHI:RTLO] = rt;
		inst[RDHI:RDLO] = rd;
		inst[OP2HI:OP2LO] = func;
		return inst;
	endfunction

	function automatic logic [DBITS-1:0] encodeI(input logic [5:0] op, input logic [5:0] rs,
			input logic [5:0] rt, input logic [DBITS-1:0] imm);
		logic [DBITS-1:0] inst;
		inst = '0;
		inst[OP1HI:OP1LO] = op;
		inst[RSHI:RSLO] = rs;
		inst[RTHI:RTLO] = rt;
		inst[IMMHI:IMMLO] = imm[IMMBITS-1:0];
		return inst;
	endfunction

	// reference ALU, comparisons signed
	function automatic logic [DBITS-1:0] refAlu(input logic [5:0] func,
			input logic [DBITS-1:0] a, input logic [DBITS-1:0] b);
		logic [DBITS-1:0] r;
		case (func)
			EQ:      r = {{(DBITS-1){1'b0}}, $signed(a) == $signed(b)};
			LT:      r = {{(DBITS-1){1'b0}}, $signed(a) < $signed(b)};
			LE:      r = {{(DBITS-1){1'b0}}, $signed(a) <= $signed(b)};
			NE:      r = {{(DBITS-1){1'b0}}, $signed(a) != $signed(b)};
			ADD:     r = a + b;
			SUB:     r = a - b;
			AND:     r = a & b;
			OR:      r = a | b;
			XOR:     r = a ^ b;
			NAND:    r = ~(a & b);
			NOR:     r = ~(a | b);
			NXOR:    r = ~(a ^ b);
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic logic [5:0] immFunc(input logic [5:0] op);
		logic [5:0] f;
		case (op)
			ANDI:    f = AND;
			ORI:     f = OR;
			XORI:    f = XOR;
			default: f = ADD;
		endcase
		return f;
	endfunction

	function automatic logic branchTaken(input logic [5:0] op,
			input logic [DBITS-1:0] a, input logic [DBITS-1:0] b);
		logic t;
		case (op)
			BEQ:     t = (a == b);
			BLT:     t = ($signed(a) < $signed(b));
			BLE:     t = ($signed(a) <= $signed(b));
			default: t = (a != b);
		endcase
		return t;
	endfunction

	// hex holds r3, ledr holds r4 (r3 + r2, or the JAL link)
	task automatic addRow(input string name, input int kind, input logic [5:0] op,
			input logic [DBITS-1:0] a, input logic [DBITS-1:0] b);
		logic [DBITS-1:0] res;
		logic [DBITS-1:0] ledrVal;
		case (kind)
			KINDALUR:    res = refAlu(op, a, b);
			KINDIMM:     res = refAlu(immFunc(op), a, b);
			KINDBRANCH:  res = branchTaken(op, a, b) ? TAKENVAL : NOTTAKENVAL;
			KINDLOADUSE: res = a;
			default:     res = a + b;
		endcase
		if (kind == KINDJAL) begin
			ledrVal = STARTPC + INSTSIZE * (JALSLOT + 1);
		end else begin
			ledrVal = res + b;
		end
		rowName.push_back(name);
		rowKind.push_back(kind);
		rowOp.push_back(op);
		rowA.push_back(a);
		rowB.push_back(b);
		rowHex.push_back(res[HEXBITS-1:0]);
		rowLedr.push_back(ledrVal[LEDRBITS-1:0]);
	endtask

	task automatic buildTable();
		op2Enum fn;
		op1Enum op;
		op1Enum immOps[4];
		op1Enum brOps[4];
		logic [DBITS-1:0] x;
		logic [DBITS-1:0] y;
		logic [DBITS-1:0] lo;
		logic [DBITS-1:0] hi;
		int k;
		fn = fn.first();
		do begin
			x = randomOperand();
			y = randomOperand();
			addRow({"alur_", fn.name()}, KINDALUR, fn, x, y);
			fn = fn.next();
		end while (fn != fn.first());
		immOps = '{ADDI, ANDI, ORI, XORI};
		for (k = 0; k < 4; k++) begin
			op = immOps[k];
			x = randomOperand();
			y = randomOperand();
			addRow({"imm_", op.name()}, KINDIMM, op, x, y);
		end
		// each branch once taken and once not taken
		brOps = '{BEQ, BLT, BLE, BNE};
		for (k = 0; k < 4; k++) begin
			op = brOps[k];
			x = randomOperand();
			y = randomOperand();
			if (x == y)
				y = x ^ 32'd1;
			lo = ($signed(x) < $signed(y)) ? x : y;
			hi = ($signed(x) < $signed(y)) ? y : x;
			case (op)
				BEQ: begin
					addRow({"br_", op.name(), "_taken"}, KINDBRANCH, op, x, x);
					addRow({"br_", op.name(), "_not"}, KINDBRANCH, op, lo, hi);
				end
				BLT: begin
					addRow({"br_", op.name(), "_taken"}, KINDBRANCH, op, lo, hi);
					addRow({"br_", op.name(), "_not"}, KINDBRANCH, op, hi, lo);
				end
				BLE: begin
					addRow({"br_", op.name(), "_taken"}, KINDBRANCH, op, x, x);
					addRow({"br_", op.name(), "_not"}, KINDBRANCH, op, hi, lo);
				end
				default: begin
					addRow({"br_", op.name(), "_taken"}, KINDBRANCH, op, lo, hi);
					addRow({"br_", op.name(), "_not"}, KINDBRANCH, op, x, x);
				end
			endcase
		end
		for (k = 0; k < 2; k++) begin
			x = randomOperand();
			y = randomOperand();
			addRow($sformatf("loaduse_%0d", k), KINDLOADUSE, LW, x, y);
		end
		x = randomOperand();
		y = randomOperand();
		addRow("jal_link", KINDJAL, JAL, x, y);
	endtask

	task automatic assemble(input int row);
		logic [DBITS-1:0] a;
		logic [DBITS-1:0] b;
		logic [DBITS-1:0] dataAddr;
		logic [5:0] op;
		a = rowA[row];
		b = rowB[row];
		op = rowOp[row];
		dataAddr = 32'h40 + INSTSIZE * row;
		prog.delete();
		prog.push_back(encodeI(ADDI, 6'd0, 6'd1, a));
		prog.push_back(encodeI(ADDI, 6'd0, 6'd2, b));
		case (rowKind[row])
			KINDALUR: prog.push_back(encodeR(op, 6'd3, 6'd1, 6'd2));
			KINDIMM:  prog.push_back(encodeI(op, 6'd1, 6'd3, b));
			KINDBRANCH: begin
				// taken lands on TAKENVAL, fall-through jumps over it
				prog.push_back(encodeI(op, 6'd1, 6'd2, 32'd2));
				prog.push_back(encodeI(ADDI, 6'd0, 6'd3, NOTTAKENVAL));
				prog.push_back(encodeI(BEQ, 6'd0, 6'd0, 32'd1));
				prog.push_back(encodeI(ADDI, 6'd0, 6'd3, TAKENVAL));
			end
			KINDLOADUSE: begin
				prog.push_back(encodeI(SW, 6'd0, 6'd1, dataAddr));
				prog.push_back(encodeI(LW, 6'd0, 6'd3, dataAddr));
			end
			default: begin
				prog.push_back(encodeR(ADD, 6'd3, 6'd1, 6'd2));
				prog.push_back(encodeI(JAL, 6'd0, 6'd4, (STARTPC >> WORDBITS) + 32'd5));
				prog.push_back(encodeI(ADDI, 6'd0, 6'd3, POISON));
			end
		endcase
		if (rowKind[row] != KINDJAL)
			prog.push_back(encodeR(ADD, 6'd4, 6'd3, 6'd2));
		prog.push_back(encodeI(SW, 6'd0, 6'd3, ADDRHEX));
		prog.push_back(encodeI(SW, 6'd0, 6'd4, ADDRLEDR));
		prog.push_back(encodeI(BEQ, 6'd0, 6'd0, 32'hFFFFFFFF));
	endtask

	task automatic loadProgram();
		logic [DBITS-1:0] wordAddr;
		int i;
		@(posedge clk);
		#2;
		reset = 1'b1;
		imemWrite = 1'b0;
		repeat (3) @(posedge clk);
		// program words go in while reset is still high
		for (i = 0; i < prog.size(); i++) begin
			#2;
			wordAddr = (STARTPC >> WORDBITS) + i;
			imemWrite = 1'b1;
			imemAddr = wordAddr[IMEMADDRBITS-WORDBITS-1:0];
			imemData = prog[i];
			@(posedge clk);
		end
		#2;
		imemWrite = 1'b0;
		reset = 1'b0;
	endtask

	task automatic checkValue(input string name, input logic [DBITS-1:0] expected,
			input logic [DBITS-1:0] actual);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic runRow(input int row);
		int cycles;
		logic done;
		assemble(row);
		loadProgram();
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < TIMEOUTCYCLES) begin
			@(negedge clk);
			done = (hexValue == rowHex[row]) && (ledr == rowLedr[row]);
			cycles++;
		end
		checks++;
		assert (done) else begin
			errors++;
			$display("%s: outputs did not reach the expected values within %0d cycles",
				rowName[row], TIMEOUTCYCLES);
		end
		checkValue({rowName[row], " hex"}, 32'(rowHex[row]), 32'(hexValue));
		checkValue({rowName[row], " ledr"}, 32'(rowLedr[row]), 32'(ledr));
	endtask

	initial begin
		int row;
		clk = 1'b0;
		reset = 1'b1;
		imemWrite = 1'b0;
		imemAddr = '0;
		imemData = '0;
		errors = 0;
		checks = 0;
		lcgState = 32'h7938;
		buildTable();
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkValue("reset hex", 32'(HEXRESET), 32'(hexValue));
		checkValue("reset ledr", 32'd0, 32'(ledr));
		for (row = 0; row < rowName.size(); row++)
			runRow(row);
		$display("rows: %0d, checks: %0d, errors: %0d", rowName.size(), checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/resultUnit.sv
verilog/pipelineCpu.sv
bench/cpuBench.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module cpuBench -f filelist.f -Mdir obj_dir

./obj_dir/VcpuBench > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

	// datapath and register file
	localparam int DBITS = 32;
	localparam int REGNOBITS = 6;
	localparam int REGWORDS = 1 << REGNOBITS;
	localparam int IMMBITS = 14;
	localparam logic [DBITS-1:0] INSTSIZE = 32'd4;
	localparam logic [DBITS-1:0] STARTPC = 32'h100;

	// memories are byte addressed by the core, word indexed inside
	localparam int IMEMADDRBITS = 12;
	localparam int DMEMADDRBITS = 12;
	localparam int WORDBITS = 2;
	localparam int IMEMWORDS = 1 << (IMEMADDRBITS - WORDBITS);
	localparam int DMEMWORDS = 1 << (DMEMADDRBITS - WORDBITS);

	// memory-mapped outputs
	localparam logic [DBITS-1:0] ADDRHEX = 32'hFFFFF000;
	localparam logic [DBITS-1:0] ADDRLEDR = 32'hFFFFF020;
	localparam int HEXBITS = 24;
	localparam int LEDRBITS = 10;
	localparam logic [HEXBITS-1:0] HEXRESET = 24'hFEDEAD;

	// instruction field positions
	localparam int OP1HI = 31;
	localparam int OP1LO = 26;
	localparam int RSHI = 25;
	localparam int RSLO = 20;
	localparam int RTHI = 19;
	localparam int RTLO = 14;
	localparam int RDHI = 13;
	localparam int RDLO = 8;
	localparam int OP2HI = 5;
	localparam int OP2LO = 0;
	localparam int IMMHI = 13;
	localparam int IMMLO = 0;

	typedef enum logic [5:0] {
		ALUR = 6'b000000,
		BEQ  = 6'b001000,
		BLT  = 6'b001001,
		BLE  = 6'b001010,
		BNE  = 6'b001011,
		JAL  = 6'b001100,
		LW   = 6'b010010,
		SW   = 6'b011010,
		ADDI = 6'b100000,
		ANDI = 6'b100100,
		ORI  = 6'b100101,
		XORI = 6'b100110
	} op1Enum;

	// comparison codes match the branches, logic codes match the immediates
	typedef enum logic [5:0] {
		EQ   = 6'b001000,
		LT   = 6'b001001,
		LE   = 6'b001010,
		NE   = 6'b001011,
		ADD  = 6'b100000,
		AND  = 6'b100100,
		OR   = 6'b100101,
		XOR  = 6'b100110,
		SUB  = 6'b101000,
		NAND = 6'b101100,
		NOR  = 6'b101101,
		NXOR = 6'b101110
	} op2Enum;

	typedef enum logic [1:0] {
		REGFILE  = 2'b00,
		FROMEXEC = 2'b01,
		FROMMEM  = 2'b10,
		FROMWB   = 2'b11
	} fwdSelEnum;

endpackage

// ==== verilog/decodeUnit.sv ====
`timescale 1ns/100ps

module decodeUnit (
	input  logic clk,
	input  logic reset,
	input  logic [cpuPkg::DBITS-1:0] instD,
	input  logic [cpuPkg::DBITS-1:0] pcPlusD,
	input  logic validD,
	input  logic redirect,
	input  logic [cpuPkg::DBITS-1:0] aluOutA,
	input  logic [cpuPkg::DBITS-1:0] wbValM,
	input  logic wrRegW,
	input  logic [cpuPkg::REGNOBITS-1:0] wRegNoW,
	input  logic [cpuPkg::DBITS-1:0] wbValW,
	output logic stall,
	output cpuPkg::op2Enum aluFuncA,
	output logic [cpuPkg::DBITS-1:0] immA,
	output logic useImmA,
	output logic isBranchA,
	output logic isJumpA,
	output logic isLoadA,
	output logic isStoreA,
	output logic wrRegA,
	output logic [cpuPkg::REGNOBITS-1:0] wRegNoA,
	output logic [cpuPkg::DBITS-1:0] pcPlusA,
	output logic [cpuPkg::DBITS-1:0] regVal1A,
	output logic [cpuPkg::DBITS-1:0] regVal2A,
	output logic validA
);
	import cpuPkg::*;

	op1Enum op1;
	logic [REGNOBITS-1:0] rs;
	logic [REGNOBITS-1:0] rt;
	logic [REGNOBITS-1:0] rd;
	logic [DBITS-1:0] immExt;

	op2Enum aluFunc;
	logic [DBITS-1:0] imm;
	logic useImm;
	logic isBranch;
	logic isJump;
	logic isLoad;
	logic isStore;
	logic wrReg;
	logic useRt;
	logic [REGNOBITS-1:0] wRegNo;

	logic [DBITS-1:0] regs [REGWORDS];
	// copy of the memory-stage destination, the memory register never flushes
	logic wrRegInMem;
	logic [REGNOBITS-1:0] wRegNoInMem;
	fwdSelEnum sel1;
	fwdSelEnum sel2;
	logic [DBITS-1:0] regVal1;
	logic [DBITS-1:0] regVal2;
	logic bubble;

	assign op1 = op1Enum'(instD[OP1HI:OP1LO]);
	assign rs = instD[RSHI:RSLO];
	assign rt = instD[RTHI:RTLO];
	assign rd = instD[RDHI:RDLO];
	assign immExt = {{(DBITS-IMMBITS){instD[IMMHI]}}, instD[IMMHI:IMMLO]};

	always_comb begin
		aluFunc = ADD;
		imm = immExt;
		useImm = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		wrReg = 1'b0;
		useRt = 1'b0;
		wRegNo = rt;
		case (op1)
			ALUR: begin
				aluFunc = op2Enum'(instD[OP2HI:OP2LO]);
				wrReg = 1'b1;
				useRt = 1'b1;
				wRegNo = rd;
			end
			ADDI, ANDI, ORI, XORI: begin
				aluFunc = op2Enum'(op1);
				useImm = 1'b1;
				wrReg = 1'b1;
			end
			BEQ, BLT, BLE, BNE: begin
				aluFunc = op2Enum'(op1);
				imm = immExt << 2;
				isBranch = 1'b1;
				useRt = 1'b1;
			end
			JAL: begin
				imm = immExt << 2;
				isJump = 1'b1;
				wrReg = 1'b1;
			end
			LW: begin
				useImm = 1'b1;
				isLoad = 1'b1;
				wrReg = 1'b1;
			end
			SW: begin
				useImm = 1'b1;
				isStore = 1'b1;
				useRt = 1'b1;
			end
			default: ;
		endcase
	end

	// youngest writer wins, r0 never matches
	function automatic fwdSelEnum pickSource(input logic [REGNOBITS-1:0] src);
		fwdSelEnum sel;
		sel = REGFILE;
		if (src == '0) begin
			sel = REGFILE;
		end else if (wrRegA && wRegNoA == src) begin
			sel = FROMEXEC;
		end else if (wrRegInMem && wRegNoInMem == src) begin
			sel = FROMMEM;
		end else if (wrRegW && wRegNoW == src) begin
			sel = FROMWB;
		end
		return sel;
	endfunction

	function automatic logic [DBITS-1:0] operandValue(input fwdSelEnum sel,
			input logic [REGNOBITS-1:0] src);
		logic [DBITS-1:0] val;
		case (sel)
			FROMEXEC: val = aluOutA;
			FROMMEM:  val = wbValM;
			FROMWB:   val = wbValW;
			default:  val = (src == '0) ? '0 : regs[src];
		endcase
		return val;
	endfunction

	always_comb begin
		sel1 = pickSource(rs);
		sel2 = pickSource(rt);
		regVal1 = operandValue(sel1, rs);
		regVal2 = operandValue(sel2, rt);
	end

	// load result is not ready until the load reaches memory
	assign stall = validD && isLoadA && (wRegNoA != '0) &&
		((wRegNoA == rs) || (useRt && wRegNoA == rt));
	assign bubble = !validD || stall || redirect;

	always_ff @(posedge clk) begin
		if (wrRegW && wRegNoW != '0) begin
			regs[wRegNoW] <= wbValW;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			isBranchA <= 1'b0;
			isJumpA <= 1'b0;
			isLoadA <= 1'b0;
			isStoreA <= 1'b0;
			wrRegA <= 1'b0;
			validA <= 1'b0;
			wrRegInMem <= 1'b0;
		end else begin
			wrRegInMem <= wrRegA;
			isBranchA <= !bubble && isBranch;
			isJumpA <= !bubble && isJump;
			isLoadA <= !bubble && isLoad;
			isStoreA <= !bubble && isStore;
			wrRegA <= !bubble && wrReg;
			validA <= !bubble;
		end
	end

	always_ff @(posedge clk) begin
		aluFuncA <= aluFunc;
		immA <= imm;
		useImmA <= useImm;
		wRegNoA <= wRegNo;
		pcPlusA <= pcPlusD;
		regVal1A <= regVal1;
		regVal2A <= regVal2;
		wRegNoInMem <= wRegNoA;
	end

endmodule

// ==== verilog/executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit (
	input  logic clk,
	input  logic reset,
	input  cpuPkg::op2Enum aluFuncA,
	input  logic [cpuPkg::DBITS-1:0] immA,
	input  logic useImmA,
	input  logic isBranchA,
	input  logic isJumpA,
	input  logic isLoadA,
	input  logic isStoreA,
	input  logic wrRegA,
	input  logic [cpuPkg::REGNOBITS-1:0] wRegNoA,
	input  logic [cpuPkg::DBITS-1:0] pcPlusA,
	input  logic [cpuPkg::DBITS-1:0] regVal1A,
	input  logic [cpuPkg::DBITS-1:0] regVal2A,
	input  logic validA,
	output logic redirect,
	output logic [cpuPkg::DBITS-1:0] redirectPc,
	output logic [cpuPkg::DBITS-1:0] aluOutA,
	output logic [cpuPkg::DBITS-1:0] aluOutM,
	output logic [cpuPkg::DBITS-1:0] storeValM,
	output logic [cpuPkg::DBITS-1:0] pcPlusM,
	output logic isLoadM,
	output logic isStoreM,
	output logic wrRegM,
	output logic [cpuPkg::REGNOBITS-1:0] wRegNoM,
	output logic selPcPlusM
);
	import cpuPkg::*;

	logic signed [DBITS-1:0] in1;
	logic signed [DBITS-1:0] in2;
	logic taken;

	assign in1 = regVal1A;
	assign in2 = useImmA ? immA : regVal2A;

	// comparisons are signed and give 0 or 1
	always_comb begin
		case (aluFuncA)
			EQ:      aluOutA = {{(DBITS-1){1'b0}}, in1 == in2};
			LT:      aluOutA = {{(DBITS-1){1'b0}}, in1 < in2};
			LE:      aluOutA = {{(DBITS-1){1'b0}}, in1 <= in2};
			NE:      aluOutA = {{(DBITS-1){1'b0}}, in1 != in2};
			ADD:     aluOutA = in1 + in2;
			SUB:     aluOutA = in1 - in2;
			AND:     aluOutA = in1 & in2;
			OR:      aluOutA = in1 | in2;
			XOR:     aluOutA = in1 ^ in2;
			NAND:    aluOutA = ~(in1 & in2);
			NOR:     aluOutA = ~(in1 | in2);
			NXOR:    aluOutA = ~(in1 ^ in2);
			default: aluOutA = '0;
		endcase
	end

	// fetch always guesses sequential, so any taken control transfer redirects
	assign taken = isBranchA && aluOutA[0];
	assign redirect = validA && (taken || isJumpA);
	assign redirectPc = isJumpA ? (regVal1A + immA) : (pcPlusA + immA);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			isLoadM <= 1'b0;
			isStoreM <= 1'b0;
			wrRegM <= 1'b0;
			selPcPlusM <= 1'b0;
		end else begin
			isLoadM <= isLoadA;
			isStoreM <= isStoreA;
			wrRegM <= wrRegA;
			// JAL writes its return address
			selPcPlusM <= isJumpA;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM <= aluOutA;
		storeValM <= regVal2A;
		pcPlusM <= pcPlusA;
		wRegNoM <= wRegNoA;
	end

endmodule

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/100ps

module fetchUnit (
	input  logic clk,
	input  logic reset,
	input  logic imemWrite,
	input  logic [cpuPkg::IMEMADDRBITS-cpuPkg::WORDBITS-1:0] imemAddr,
	input  logic [cpuPkg::DBITS-1:0] imemData,
	input  logic stall,
	input  logic redirect,
	input  logic [cpuPkg::DBITS-1:0] redirectPc,
	output logic [cpuPkg::DBITS-1:0] instD,
	output logic [cpuPkg::DBITS-1:0] pcPlusD,
	output logic validD
);
	import cpuPkg::*;

	logic [DBITS-1:0] pc;
	logic [DBITS-1:0] pcPlus;
	logic [DBITS-1:0] instF;
	logic [DBITS-1:0] imem [IMEMWORDS];

	// always predict the sequential address
	assign pcPlus = pc + INSTSIZE;
	assign instF = imem[pc[IMEMADDRBITS-1:WORDBITS]];

	// program load port, driven only while reset is held
	always_ff @(posedge clk) begin
		if (imemWrite) begin
			imem[imemAddr] <= imemData;
		end
	end

	// redirect wins over stall since the stalled instruction is being discarded
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= STARTPC;
			validD <= 1'b0;
		end else if (redirect) begin
			pc <= redirectPc;
			validD <= 1'b0;
		end else if (!stall) begin
			pc <= pcPlus;
			validD <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			instD <= instF;
			pcPlusD <= pcPlus;
		end
	end

endmodule

// ==== verilog/pipelineCpu.sv ====
`timescale 1ns/100ps

module pipelineCpu (
	input  logic clk,
	input  logic reset,
	input  logic imemWrite,
	input  logic [cpuPkg::IMEMADDRBITS-cpuPkg::WORDBITS-1:0] imemAddr,
	input  logic [cpuPkg::DBITS-1:0] imemData,
	output logic [cpuPkg::HEXBITS-1:0] hexValue,
	output logic [cpuPkg::LEDRBITS-1:0] ledr
);
	import cpuPkg::*;

	// fetch/decode
	logic [DBITS-1:0] instD;
	logic [DBITS-1:0] pcPlusD;
	logic validD;
	logic stall;
	logic redirect;
	logic [DBITS-1:0] redirectPc;

	// decode/execute
	op2Enum aluFuncA;
	logic [DBITS-1:0] immA;
	logic useImmA;
	logic isBranchA;
	logic isJumpA;
	logic isLoadA;
	logic isStoreA;
	logic wrRegA;
	logic [REGNOBITS-1:0] wRegNoA;
	logic [DBITS-1:0] pcPlusA;
	logic [DBITS-1:0] regVal1A;
	logic [DBITS-1:0] regVal2A;
	logic validA;
	logic [DBITS-1:0] aluOutA;

	// execute/memory and writeback
	logic [DBITS-1:0] aluOutM;
	logic [DBITS-1:0] storeValM;
	logic [DBITS-1:0] pcPlusM;
	logic isLoadM;
	logic isStoreM;
	logic wrRegM;
	logic [REGNOBITS-1:0] wRegNoM;
	logic selPcPlusM;
	logic [DBITS-1:0] wbValM;
	logic wrRegW;
	logic [REGNOBITS-1:0] wRegNoW;
	logic [DBITS-1:0] wbValW;

	fetchUnit i_fetch (
		.clk(clk), .reset(reset),
		.imemWrite(imemWrite), .imemAddr(imemAddr), .imemData(imemData),
		.stall(stall), .redirect(redirect), .redirectPc(redirectPc),
		.instD(instD), .pcPlusD(pcPlusD), .validD(validD)
	);

	decodeUnit i_decode (
		.clk(clk), .reset(reset),
		.instD(instD), .pcPlusD(pcPlusD), .validD(validD), .redirect(redirect),
		.aluOutA(aluOutA), .wbValM(wbValM),
		.wrRegW(wrRegW), .wRegNoW(wRegNoW), .wbValW(wbValW),
		.stall(stall),
		.aluFuncA(aluFuncA), .immA(immA), .useImmA(useImmA),
		.isBranchA(isBranchA), .isJumpA(isJumpA), .isLoadA(isLoadA), .isStoreA(isStoreA),
		.wrRegA(wrRegA), .wRegNoA(wRegNoA), .pcPlusA(pcPlusA),
		.regVal1A(regVal1A), .regVal2A(regVal2A), .validA(validA)
	);

	executeUnit i_execute (
		.clk(clk), .reset(reset),
		.aluFuncA(aluFuncA), .immA(immA), .useImmA(useImmA),
		.isBranchA(isBranchA), .isJumpA(isJumpA), .isLoadA(isLoadA), .isStoreA(isStoreA),
		.wrRegA(wrRegA), .wRegNoA(wRegNoA), .pcPlusA(pcPlusA),
		.regVal1A(regVal1A), .regVal2A(regVal2A), .validA(validA),
		.redirect(redirect), .redirectPc(redirectPc), .aluOutA(aluOutA),
		.aluOutM(aluOutM), .storeValM(storeValM), .pcPlusM(pcPlusM),
		.isLoadM(isLoadM), .isStoreM(isStoreM), .wrRegM(wrRegM),
		.wRegNoM(wRegNoM), .selPcPlusM(selPcPlusM)
	);

	resultUnit i_result (
		.clk(clk), .reset(reset),
		.aluOutM(aluOutM), .storeValM(storeValM), .pcPlusM(pcPlusM),
		.isLoadM(isLoadM), .isStoreM(isStoreM), .wrRegM(wrRegM),
		.wRegNoM(wRegNoM), .selPcPlusM(selPcPlusM),
		.wbValM(wbValM), .wrRegW(wrRegW), .wRegNoW(wRegNoW), .wbValW(wbValW),
		.hexValue(hexValue), .ledr(ledr)
	);

endmodule

// ==== verilog/resultUnit.sv ====
`timescale 1ns/100ps

module resultUnit (
	input  logic clk,
	input  logic reset,
	input  logic [cpuPkg::DBITS-1:0] aluOutM,
	input  logic [cpuPkg::DBITS-1:0] storeValM,
	input  logic [cpuPkg::DBITS-1:0] pcPlusM,
	input  logic isLoadM,
	input  logic isStoreM,
	input  logic wrRegM,
	input  logic [cpuPkg::REGNOBITS-1:0] wRegNoM,
	input  logic selPcPlusM,
	output logic [cpuPkg::DBITS-1:0] wbValM,
	output logic wrRegW,
	output logic [cpuPkg::REGNOBITS-1:0] wRegNoW,
	output logic [cpuPkg::DBITS-1:0] wbValW,
	output logic [cpuPkg::HEXBITS-1:0] hexValue,
	output logic [cpuPkg::LEDRBITS-1:0] ledr
);
	import cpuPkg::*;

	logic [DBITS-1:0] dmem [DMEMWORDS];
	logic [DMEMADDRBITS-WORDBITS-1:0] dIndex;
	logic selHex;
	logic selLedr;
	logic selDmem;
	logic [DBITS-1:0] loadData;

	// address decode of the memory-stage address
	assign selHex = (aluOutM == ADDRHEX);
	assign selLedr = (aluOutM == ADDRLEDR);
	assign selDmem = !selHex && !selLedr;
	assign dIndex = aluOutM[DMEMADDRBITS-1:WORDBITS];

	always_ff @(posedge clk) begin
		if (isStoreM && selDmem) begin
			dmem[dIndex] <= storeValM;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hexValue <= HEXRESET;
			ledr <= '0;
		end else if (isStoreM) begin
			if (selHex) begin
				hexValue <= storeValM[HEXBITS-1:0];
			end
			if (selLedr) begin
				ledr <= storeValM[LEDRBITS-1:0];
			end
		end
	end

	// read mux in place of a shared data bus
	always_comb begin
		if (selHex) begin
			loadData = {{(DBITS-HEXBITS){1'b0}}, hexValue};
		end else if (selLedr) begin
			loadData = {{(DBITS-LEDRBITS){1'b0}}, ledr};
		end else begin
			loadData = dmem[dIndex];
		end
	end

	assign wbValM = isLoadM ? loadData : (selPcPlusM ? pcPlusM : aluOutM);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wrRegW <= 1'b0;
		end else begin
			wrRegW <= wrRegM;
		end
	end

	always_ff @(posedge clk) begin
		wRegNoW <= wRegNoM;
		wbValW <= wbValM;
	end

endmodule
